/* hw/qpi_dma_macros.svh */
// QPI DMA reader sizes
`ifndef QPI_DMA_MACROS_SVH
`define QPI_DMA_MACROS_SVH

// FIFO depth in 32-bit words, power of two
`define QD_FIFO_WORDS 16

// longest burst in words
// power of two, no larger than the FIFO depth
`define QD_BURST_LEN 4

// byte address width on the QPI bus
`define QD_ADDR_WIDTH 24

`endif

/* hw/qpi_dma_pkg.sv */
// QPI DMA reader types
`default_nettype none
`include "qpi_dma_macros.svh"

package qpi_dma_pkg;

	localparam int ptr_w = $clog2(`QD_FIFO_WORDS); // fifo word index bits
	localparam int ofs_w = $clog2(`QD_BURST_LEN); // offset-in-burst bits

	// controller states
	typedef enum logic [1:0] {
		ST_RESTART = 2'd0, // waiting for qpi idle after abort or reset
		ST_IDLE    = 2'd1, // between bursts
		ST_BURST   = 2'd2  // qpi_do_read high, words arriving
	} dma_state_t;

	typedef logic [ptr_w-1:0] word_ptr_t; // fifo word index
	typedef logic [ofs_w-1:0] burst_ofs_t; // word offset inside a burst
	typedef logic [`QD_ADDR_WIDTH-1:0] addr_t; // byte address

endpackage

`default_nettype wire

/* hw/qpi_dma_if.sv */
// DMA reader internal buses
`default_nettype none

// burst sequencing between fsm, beat counter and address tracker
interface burst_if;
	logic load; // one-cycle pulse at burst start
	qpi_dma_pkg::burst_ofs_t start_ofs; // low word-index bits of write addr
	logic beat; // word accepted during a burst
	logic last; // current beat is final word of aligned burst

	modport ctrl (output load, output beat, input last);
	modport cnt (input load, input start_ofs, input beat, output last);
	modport trk (output start_ofs);
endinterface

// address control and status between fsm and address tracker
interface addr_if;
	logic rewind; // hold both addrs at addr_start
	logic wr_step; // write addr += 4
	logic room_ok; // fifo can take a full burst
	logic more_to_fetch; // write addr below addr_end
	logic last_fetch; // next word fetched is the final one

	modport ctrl (output rewind, output wr_step,
		input room_ok, input more_to_fetch, input last_fetch);
	modport trk (input rewind, input wr_step,
		output room_ok, output more_to_fetch, output last_fetch);
endinterface

`default_nettype wire

/* hw/dma_ctrl_fsm.sv */
// DMA burst sequencer
`default_nettype none

module dma_ctrl_fsm (
	input  logic   clk,
	input  logic   rst,
	input  logic   run, // low aborts and rewinds
	input  logic   qpi_is_idle, // no qpi transaction in flight
	input  logic   qpi_next_word, // one word from memory this cycle
	output logic   qpi_do_read, // registered request level
	burst_if.ctrl  bus,
	addr_if.ctrl   adr
);

	qpi_dma_pkg::dma_state_t state; // current state
	qpi_dma_pkg::dma_state_t state_nxt;
	logic do_read_nxt; // next qpi_do_read
	logic start_burst; // all conditions to issue a burst
	logic beat; // word landing inside a burst
	logic burst_end; // this word closes the burst

	// a new burst needs an idle controller, fifo room and words left
	assign start_burst = run && (state == qpi_dma_pkg::ST_IDLE) && qpi_is_idle
		&& adr.room_ok && adr.more_to_fetch;

	assign beat = qpi_next_word && (state == qpi_dma_pkg::ST_BURST);

	// stop at aligned boundary or at addr_end, whichever comes first
	assign burst_end = beat && (bus.last || adr.last_fetch);

	assign bus.load = start_burst; // counter picks up start offset
	assign bus.beat = beat;
	assign adr.wr_step = beat; // each accepted word moves write addr
	assign adr.rewind = (state == qpi_dma_pkg::ST_RESTART); // held all through restart

	always_comb begin
		state_nxt = state; // default hold
		do_read_nxt = qpi_do_read;
		if (!run) begin
			// abort from any state, read side rewinds next cycle
			state_nxt = qpi_dma_pkg::ST_RESTART;
			do_read_nxt = 1'b0;
		end else begin
			case (state)
				qpi_dma_pkg::ST_RESTART: begin
					if (qpi_is_idle) begin // old transaction drained
						state_nxt = qpi_dma_pkg::ST_IDLE;
					end
				end
				qpi_dma_pkg::ST_IDLE: begin
					if (start_burst) begin
						state_nxt = qpi_dma_pkg::ST_BURST;
						do_read_nxt = 1'b1; // request rises at next edge
					end
				end
				qpi_dma_pkg::ST_BURST: begin
					if (burst_end) begin
						state_nxt = qpi_dma_pkg::ST_IDLE;
						do_read_nxt = 1'b0; // drop request after last word
					end
				end
				default: begin
					state_nxt = qpi_dma_pkg::ST_RESTART; // recover
					do_read_nxt = 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= qpi_dma_pkg::ST_RESTART;
			qpi_do_read <= 1'b0;
		end else begin
			state <= state_nxt;
			qpi_do_read <= do_read_nxt;
		end
	end

endmodule

`default_nettype wire

/* hw/burst_counter.sv */
// Aligned burst beat counter
`default_nettype none
`include "qpi_dma_macros.svh"

module burst_counter (
	input  logic  clk,
	input  logic  rst,
	burst_if.cnt  bus
);

	// final offset of an aligned burst, all ones
	localparam qpi_dma_pkg::burst_ofs_t last_ofs =
		qpi_dma_pkg::burst_ofs_t'(`QD_BURST_LEN - 1);

	qpi_dma_pkg::burst_ofs_t cnt; // offset of the word expected next

	// Starting from the write address offset rather than zero means a burst
	// begun mid-block still stops on the block boundary, so an unaligned
	// addr_start gives a short first burst and aligned ones after it.
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (bus.load) begin
			cnt <= bus.start_ofs; // sync to write addr at burst start
		end else if (bus.beat) begin
			cnt <= cnt + 1'b1; // wraps at burst length
		end
	end

	// level, qualified by beat in the fsm
	assign bus.last = (cnt == last_ofs);

endmodule

`default_nettype wire

/* hw/dma_addr_track.sv */
// DMA read and write address tracker
`default_nettype none
`include "qpi_dma_macros.svh"

module dma_addr_track (
	input  logic                      clk,
	input  logic                      rst,
	input  qpi_dma_pkg::addr_t        addr_start, // byte addr, first word
	input  qpi_dma_pkg::addr_t        addr_end, // byte addr, one past last word
	input  logic                      do_read, // consumer pull strobe
	addr_if.trk                       adr,
	burst_if.trk                      bus,
	output qpi_dma_pkg::addr_t        wr_addr, // next byte addr to fetch
	output qpi_dma_pkg::word_ptr_t    wr_ptr, // fifo write word index
	output qpi_dma_pkg::word_ptr_t    rd_ptr, // fifo read word index
	output logic                      ready, // word available to consumer
	output logic                      all_done // everything consumed
);

	localparam int ptr_w = $bits(qpi_dma_pkg::word_ptr_t);
	localparam int ofs_w = $bits(qpi_dma_pkg::burst_ofs_t);

	localparam qpi_dma_pkg::addr_t word_bytes = qpi_dma_pkg::addr_t'(4);

	// fill limit that still leaves space for one full burst
	localparam qpi_dma_pkg::addr_t room_limit =
		qpi_dma_pkg::addr_t'((`QD_FIFO_WORDS - `QD_BURST_LEN) * 4);

	qpi_dma_pkg::addr_t rd_addr; // next byte addr handed to consumer
	qpi_dma_pkg::addr_t fill; // bytes held in fifo
	qpi_dma_pkg::addr_t wr_addr_nxt; // write addr after this fetch
	logic pull; // consumer takes a word

	assign pull = ready && do_read;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_addr <= '0;
			rd_addr <= '0;
		end else if (adr.rewind) begin
			wr_addr <= addr_start; // both sides restart together
			rd_addr <= addr_start;
		end else begin
			if (adr.wr_step) begin
				wr_addr <= wr_addr_nxt;
			end
			if (pull) begin
				rd_addr <= rd_addr + word_bytes;
			end
		end
	end

	// word index = byte addr bits above the byte lane
	assign wr_ptr = wr_addr[ptr_w+1:2];
	assign rd_ptr = rd_addr[ptr_w+1:2];
	assign bus.start_ofs = wr_ptr[ofs_w-1:0]; // position inside aligned burst

	assign ready = (wr_ptr != rd_ptr); // fall-through, empty when equal
	assign all_done = (rd_addr >= addr_end);

	assign wr_addr_nxt = wr_addr + word_bytes;
	assign fill = wr_addr - rd_addr; // modulo width, wr never behind rd
	assign adr.room_ok = (fill < room_limit);
	assign adr.more_to_fetch = (wr_addr < addr_end);
	assign adr.last_fetch = (wr_addr_nxt >= addr_end);

endmodule

`default_nettype wire

/* hw/dma_fifo_mem.sv */
// DMA FIFO word RAM
`default_nettype none
`include "qpi_dma_macros.svh"

module dma_fifo_mem (
	input  logic                    clk,
	input  logic                    w_en, // store w_data at w_ptr
	input  qpi_dma_pkg::word_ptr_t  w_ptr,
	input  logic [31:0]             w_data,
	input  qpi_dma_pkg::word_ptr_t  r_ptr,
	output logic [31:0]             r_data // combinational, fall-through
);

	logic [31:0] ram [`QD_FIFO_WORDS]; // word storage, no reset

	always_ff @(posedge clk) begin
		if (w_en) begin
			ram[w_ptr] <= w_data;
		end
	end

	// async read so rdata is valid together with ready
	assign r_data = ram[r_ptr];

endmodule

`default_nettype wire

/* hw/qpi_dma_rdr.sv */
// Buffered QPI DMA reader
`default_nettype none
`include "qpi_dma_macros.svh"

module qpi_dma_rdr (
	input  logic                      clk,
	input  logic                      rst,

	// consumer side
	input  logic [`QD_ADDR_WIDTH-1:0] addr_start, // byte addr
	input  logic [`QD_ADDR_WIDTH-1:0] addr_end, // byte addr, exclusive
	input  logic                      run, // low aborts transfer
	output logic                      ready, // word waiting in fifo
	output logic                      all_done, // range fully consumed
	input  logic                      do_read, // take current word
	output logic [31:0]               rdata, // valid with ready

	// qpi memory controller side
	output logic                      qpi_do_read,
	input  logic                      qpi_next_word,
	output logic [`QD_ADDR_WIDTH-1:0] qpi_addr,
	input  logic [31:0]               qpi_rdata,
	input  logic                      qpi_is_idle
);

	qpi_dma_pkg::word_ptr_t wr_ptr; // fifo write index
	qpi_dma_pkg::word_ptr_t rd_ptr; // fifo read index

	burst_if bus ();
	addr_if  adr ();

	dma_ctrl_fsm i_dma_ctrl_fsm (
		.clk           (clk),
		.rst           (rst),
		.run           (run),
		.qpi_is_idle   (qpi_is_idle),
		.qpi_next_word (qpi_next_word),
		.qpi_do_read   (qpi_do_read),
		.bus           (bus.ctrl),
		.adr           (adr.ctrl)
	);

	burst_counter i_burst_counter (
		.clk (clk),
		.rst (rst),
		.bus (bus.cnt)
	);

	dma_addr_track i_dma_addr_track (
		.clk        (clk),
		.rst        (rst),
		.addr_start (addr_start),
		.addr_end   (addr_end),
		.do_read    (do_read),
		.adr        (adr.trk),
		.bus        (bus.trk),
		.wr_addr    (qpi_addr), // fetch addr goes straight to the bus
		.wr_ptr     (wr_ptr),
		.rd_ptr     (rd_ptr),
		.ready      (ready),
		.all_done   (all_done)
	);

	// every returned word lands at the write index, even after an abort
	dma_fifo_mem i_dma_fifo_mem (
		.clk    (clk),
		.w_en   (qpi_next_word),
		.w_ptr  (wr_ptr),
		.w_data (qpi_rdata),
		.r_ptr  (rd_ptr),
		.r_data (rdata)
	);

endmodule

`default_nettype wire

/* bench/tb_qpi_dma_rdr.sv */
// QPI DMA reader testbench
`default_nettype none
`include "qpi_dma_macros.svh"

module tb_qpi_dma_rdr;

	localparam int n_tests = 6;
	localparam int n_cols = 6; // values per test row
	localparam logic [31:0] golden = 32'h9e37_79b9; // memory image multiplier

	logic clk;
	logic rst;
	logic [`QD_ADDR_WIDTH-1:0] addr_start;
	logic [`QD_ADDR_WIDTH-1:0] addr_end;
	logic run;
	logic ready;
	logic all_done;
	logic do_read;
	logic [31:0] rdata;
	logic qpi_do_read;
	logic qpi_next_word;
	logic [`QD_ADDR_WIDTH-1:0] qpi_addr;
	logic [31:0] qpi_rdata;
	logic qpi_is_idle;

	logic [31:0] stim [0:n_tests*n_cols]; // seed, then rows
	logic [31:0] mem_seed;
	integer seed;
	int wd_cycles; // watchdog limit, 0 until computed
	int sum_words;
	int max_gap;
	int max_stall;
	int pass_cnt;
	int fail_cnt;
	int errors; // in the current test

	bit in_word; // memory model has a word in flight
	bit prev_do_read;
	int gap_left; // cycles before the word is returned
	int gap_max;
	int burst_words; // words served in the open burst
	int burst_block; // aligned block of the burst's first word

	always #2 clk = ~clk;

	qpi_dma_rdr i_qpi_dma_rdr (
		.clk           (clk),
		.rst           (rst),
		.addr_start    (addr_start),
		.addr_end      (addr_end),
		.run           (run),
		.ready         (ready),
		.all_done      (all_done),
		.do_read       (do_read),
		.rdata         (rdata),
		.qpi_do_read   (qpi_do_read),
		.qpi_next_word (qpi_next_word),
		.qpi_addr      (qpi_addr),
		.qpi_rdata     (qpi_rdata),
		.qpi_is_idle   (qpi_is_idle)
	);

	// psram contents, word index n
	function automatic logic [31:0] mem_word(input logic [31:0] n);
		return (n * golden) ^ mem_seed; // product wraps at 32 bits
	endfunction

	task automatic check_burst(input int widx);
		if (burst_words == 0) begin
			burst_block = widx / `QD_BURST_LEN; // first word opens the burst
		end
		burst_words++;
		if (burst_words > `QD_BURST_LEN) begin
			$display("burst longer than %0d words at word %h", `QD_BURST_LEN, widx);
			errors++;
		end
		if (widx / `QD_BURST_LEN != burst_block) begin
			$display("burst crosses an aligned block boundary at word %h", widx);
			errors++;
		end
		if (qpi_addr >= addr_end) begin
			$display("word requested at %h, at or beyond addr_end %h", qpi_addr, addr_end);
			errors++;
		end
	endtask

	// word-level qpi controller, one call per falling edge
	task automatic serve_memory();
		int widx;
		qpi_next_word = 1'b0;
		if (qpi_do_read && !prev_do_read && in_word) begin
			$display("request raised while the memory was still busy, addr %h", qpi_addr);
			errors++;
		end
		prev_do_read = qpi_do_read;
		if (!qpi_do_read) begin
			burst_words = 0; // burst closed
		end
		if (!in_word && qpi_do_read) begin
			in_word = 1'b1;
			gap_left = $unsigned($random(seed)) % (gap_max + 1);
		end
		if (in_word) begin
			if (gap_left == 0) begin
				in_word = 1'b0;
				widx = 32'(qpi_addr >> 2);
				qpi_next_word = 1'b1;
				qpi_rdata = mem_word(widx);
				if (qpi_do_read) begin
					check_burst(widx); // words finished after an abort are not a burst
				end
			end else begin
				gap_left--;
			end
		end
		qpi_is_idle = !(in_word || qpi_do_read || qpi_next_word);
	endtask

	task automatic hold_run_low(input int n);
		run = 1'b0;
		do_read = 1'b0;
		repeat (n) begin
			@(negedge clk);
			serve_memory();
		end
	endtask

	task automatic run_test(input int t);
		logic [31:0] a_s;
		logic [31:0] a_e;
		logic [31:0] stall;
		logic [31:0] drop;
		logic [31:0] exp_cnt;
		logic [31:0] want;
		logic [31:0] fill;
		int taken;
		int cycles;
		bit dropped;
		bit finished;
		a_s = stim[1 + t*n_cols];
		a_e = stim[2 + t*n_cols];
		stall = stim[3 + t*n_cols];
		gap_max = stim[4 + t*n_cols];
		drop = stim[5 + t*n_cols];
		exp_cnt = stim[6 + t*n_cols];
		errors = 0;
		taken = 0;
		cycles = 0;
		dropped = 1'b0;
		finished = 1'b0;
		addr_start = a_s[`QD_ADDR_WIDTH-1:0];
		addr_end = a_e[`QD_ADDR_WIDTH-1:0];
		hold_run_low(3); // rewind to the new range
		run = 1'b1;
		while (!finished) begin
			@(negedge clk);
			serve_memory();
			cycles++;
			fill = 32'(qpi_addr) - a_s - 32'(4 * taken);
			if (!dropped && drop != 0 && cycles >= drop && qpi_do_read) begin
				dropped = 1'b1; // abort inside a burst
				hold_run_low(3);
				run = 1'b1;
				taken = 0; // whole range again from addr_start
			end else if (all_done) begin
				finished = 1'b1;
				do_read = 1'b0;
				if (taken != exp_cnt) begin
					$display("Mismatch word count: got %h, expected %h", taken, exp_cnt);
					errors++;
				end
			end else if (taken == exp_cnt) begin
				$display("all_done still low after the last word was taken");
				errors++;
				finished = 1'b1;
			end else begin
				if (fill > `QD_FIFO_WORDS * 4) begin
					$display("Mismatch qpi_addr: %h is %h bytes ahead of read address %h",
						qpi_addr, fill, a_s + 32'(4 * taken));
					errors++;
				end
				do_read = (($unsigned($random(seed)) % 100) >= stall);
				if (ready && do_read) begin
					want = mem_word(32'(a_s >> 2) + 32'(taken));
					if (rdata !== want) begin
						$display("Mismatch rdata: got %h, expected %h (word %0d)",
							rdata, want, taken);
						errors++;
					end
					taken++;
				end
			end
		end
		repeat (8) begin // fifo must stay empty once done
			@(negedge clk);
			serve_memory();
			if (ready || !all_done) begin
				$display("after the last word ready is %b and all_done is %b", ready, all_done);
				errors++;
			end
		end
		if (drop != 0 && !dropped) begin
			$display("run was never dropped inside a burst");
			errors++;
		end
		run = 1'b0;
		$display("test %0d %s: %0d words from %h, %0d cycles, %0d errors",
			t, (errors == 0) ? "ok" : "FAILED", exp_cnt, a_s, cycles, errors);
		if (errors == 0) begin
			pass_cnt++;
		end else begin
			fail_cnt++;
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		addr_start = '0;
		addr_end = '0;
		run = 1'b0;
		do_read = 1'b0;
		qpi_next_word = 1'b0;
		qpi_rdata = '0;
		qpi_is_idle = 1'b1;
		seed = 32'h01e7_54bd;
		in_word = 1'b0;
		prev_do_read = 1'b0;
		gap_left = 0;
		gap_max = 0;
		burst_words = 0;
		burst_block = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		errors = 0;
		sum_words = 0;
		max_gap = 0;
		max_stall = 0;
		$readmemh("bench/qpi_dma_stimulus.txt", stim);
		mem_seed = stim[0];
		for (int t = 0; t < n_tests; t++) begin
			sum_words += stim[6 + t*n_cols];
			if (stim[4 + t*n_cols] > max_gap) begin
				max_gap = stim[4 + t*n_cols];
			end
			if (stim[3 + t*n_cols] > max_stall) begin
				max_stall = stim[3 + t*n_cols];
			end
		end
		// stall cost is cycles per word at the worst stall rate
		wd_cycles = sum_words * (max_gap + 1 + 100 / (100 - max_stall)) * 8 + 64 * n_tests;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		for (int t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("timeout after %0d cycles, controller stuck in %s",
			wd_cycles, i_qpi_dma_rdr.i_dma_ctrl_fsm.state.name());
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* qpi_dma.f */
+incdir+hw
hw/qpi_dma_pkg.sv
hw/qpi_dma_if.sv
hw/dma_ctrl_fsm.sv
hw/burst_counter.sv
hw/dma_addr_track.sv
hw/dma_fifo_mem.sv
hw/qpi_dma_rdr.sv
bench/tb_qpi_dma_rdr.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f qpi_dma.f \
	--top-module tb_qpi_dma_rdr -o tb_qpi_dma_rdr \
	&& ./obj_dir/tb_qpi_dma_rdr | tee sim.log \
	|| { echo "build or run error"; exit 1; }
grep -q "Verification failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Verification passed" sim.log || { echo "no result in sim.log"; exit 1; }
echo "PASS"
exit 0

/* bench/qpi_dma_stimulus.txt */
// first value: memory image seed, memory word n = n * 9e3779b9 ^ seed
// then one row per test, all hex:
// addr_start addr_end stall_pct gap_max drop_cycle word_count
5a3c96e1

// aligned range, consumer never stalls
00000100 00000140 00 02 00 10

// unaligned start, short first burst
00000204 00000238 14 03 00 0d

// 90 percent stall, fifo fills up
00001000 00001100 5a 01 00 40

// run dropped mid-burst, then restarted
0000200c 00002060 1e 04 14 15

// three words ending inside a block
00003008 00003014 00 00 00 03

// back-to-back words with an abort
000a0040 000a0100 32 00 18 30
